// ==== design/osc_ui_pkg.sv ====
package osc_ui_pkg;

    // Datapath widths
    localparam int SETTING_W = 20;
    localparam int OUT_W     = 12;
    localparam int POS_W     = 12;
    localparam int OFS_W     = 11;

    ////////////////////
    // Setting accumulators
    ////////////////////
    localparam logic [SETTING_W-1:0] ADC_RESET_VALUE = 20'd960;
    localparam logic [SETTING_W-1:0] ADC_MIN         = 20'd5;
    localparam logic [SETTING_W-1:0] ADC_RELOAD      = 20'd100;

    // Horizontal command regions, exclusive limits
    localparam logic [POS_W-1:0] ZONE_TRIG_CLK_MAX   = 12'd100;
    localparam logic [POS_W-1:0] ZONE_TRIG_LEVEL_MAX = 12'd500;
    localparam logic [POS_W-1:0] ZONE_ADC_MAX        = 12'd1000;

    // Command lockout after each accepted step
    localparam int HOLD_CYCLES = 1000;

    ////////////////////
    // Display window, inclusive on both ends
    ////////////////////
    localparam logic [POS_W-1:0] DISP_X = 12'd200;
    localparam logic [POS_W-1:0] DISP_W = 12'd600;
    localparam logic [POS_W-1:0] DISP_Y = 12'd100;
    localparam logic [POS_W-1:0] DISP_H = 12'd400;

    // Target of a step command
    typedef enum logic [1:0] {
        SEL_ADC,
        SEL_TRIG_LEVEL,
        SEL_TRIG_CLK
    } setting_sel_t;

endpackage

// ==== design/mouse_if.sv ====
`timescale 1ns/1ns

interface mouse_if;

    // Decoded button levels
    logic left;
    logic right;
    logic middle;

    // Pointer position in screen pixels
    logic [osc_ui_pkg::POS_W-1:0] x;
    logic [osc_ui_pkg::POS_W-1:0] y;

    // Command decode needs all buttons but only the column
    modport ctrl (input left, right, middle, x);

    // Chart drag needs the left button and both coordinates
    modport drag (input left, x, y);

endinterface

// ==== design/hold_timer.sv ====
`timescale 1ns/1ns

module hold_timer #(
    parameter int CYCLES = osc_ui_pkg::HOLD_CYCLES
) (
    input  logic clk,
    input  logic rst,
    input  logic start,
    output logic done
);

    localparam int CNT_W = (CYCLES > 1) ? $clog2(CYCLES) : 1;

    logic             running;
    logic [CNT_W-1:0] remaining;

    // Loaded so that done lands CYCLES cycles after start
    always_ff @(posedge clk) begin
        if (rst) begin
            running   <= 1'b0;
            remaining <= '0;
        end else if (start) begin
            running   <= 1'b1;
            remaining <= CNT_W'(CYCLES - 1);
        end else if (running) begin
            if (remaining == '0) begin
                running <= 1'b0;
            end else begin
                remaining <= remaining - 1'b1;
            end
        end
    end

    // High for the last counted cycle only
    assign done = running && (remaining == '0);

endmodule

// ==== design/setting_counter.sv ====
`timescale 1ns/1ns

module setting_counter #(
    parameter logic [osc_ui_pkg::SETTING_W-1:0] RESET_VALUE = '0,
    parameter bit                               HAS_RELOAD  = 1'b0
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        up,
    input  logic                        dn,
    input  logic                        reload,
    output logic [osc_ui_pkg::OUT_W-1:0] value,
    output logic                        low
);

    // Sixteen steps per output LSB
    localparam int FRAC_W = 4;

    logic [osc_ui_pkg::SETTING_W-1:0] acc;
    logic                             en;

    assign en = up | dn;

    always_ff @(posedge clk) begin
        if (rst) begin
            acc <= RESET_VALUE;
        end else if (en) begin
            if (HAS_RELOAD && reload) begin
                acc <= osc_ui_pkg::ADC_RELOAD;
            end else if (up) begin
                acc <= acc + 1'b1;
            end else begin
                acc <= acc - 1'b1;
            end
        end
    end

    assign value = acc[osc_ui_pkg::OUT_W+FRAC_W-1:FRAC_W];
    assign low   = HAS_RELOAD && (acc < osc_ui_pkg::ADC_MIN);

endmodule

// ==== design/ui_controller.sv ====
`timescale 1ns/1ns

module ui_controller (
    input  logic                     clk,
    input  logic                     rst,
    mouse_if.ctrl                    mouse,
    input  logic                     adc_low,
    input  logic                     hold_done,
    output logic                     step_up,
    output logic                     step_dn,
    output logic                     adc_reload,
    output logic                     hold_start,
    output osc_ui_pkg::setting_sel_t step_sel
);

    typedef enum logic {
        IDLE,
        HOLD
    } state_t;

    state_t                   state;
    logic                     side_btn;
    logic                     mid_cmd;
    logic                     in_clk_zone;
    logic                     in_level_zone;
    logic                     in_adc_zone;
    logic                     cmd_valid;
    logic                     cmd_up;
    logic                     cmd_reload;
    osc_ui_pkg::setting_sel_t cmd_sel;

    ////////////////////
    // Region and button decode
    ////////////////////
    assign side_btn      = mouse.right | mouse.left;
    assign mid_cmd       = mouse.middle & side_btn;
    assign in_clk_zone   = mouse.x < osc_ui_pkg::ZONE_TRIG_CLK_MAX;
    assign in_level_zone = (mouse.x > osc_ui_pkg::ZONE_TRIG_CLK_MAX) &&
                           (mouse.x < osc_ui_pkg::ZONE_TRIG_LEVEL_MAX);
    assign in_adc_zone   = (mouse.x > osc_ui_pkg::ZONE_TRIG_LEVEL_MAX) &&
                           (mouse.x < osc_ui_pkg::ZONE_ADC_MAX);

    // Priority order; right beats left when both are held
    always_comb begin
        cmd_valid  = 1'b0;
        cmd_up     = mouse.right;
        cmd_reload = 1'b0;
        cmd_sel    = osc_ui_pkg::SEL_ADC;
        if (adc_low) begin
            cmd_valid  = 1'b1;
            cmd_up     = 1'b1;
            cmd_reload = 1'b1;
        end else if (mid_cmd && in_adc_zone) begin
            cmd_valid = 1'b1;
        end else if (mid_cmd && in_level_zone) begin
            cmd_valid = 1'b1;
            cmd_sel   = osc_ui_pkg::SEL_TRIG_LEVEL;
        end else if (side_btn && in_clk_zone) begin
            cmd_valid = 1'b1;
            cmd_sel   = osc_ui_pkg::SEL_TRIG_CLK;
        end
    end

    ////////////////////
    // FSM and strobe registers
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= IDLE;
            step_up    <= 1'b0;
            step_dn    <= 1'b0;
            adc_reload <= 1'b0;
            hold_start <= 1'b0;
            step_sel   <= osc_ui_pkg::SEL_ADC;
        end else begin
            // Strobes last a single cycle
            step_up    <= 1'b0;
            step_dn    <= 1'b0;
            adc_reload <= 1'b0;
            hold_start <= 1'b0;
            case (state)
                IDLE: begin
                    if (cmd_valid) begin
                        step_up    <= cmd_up;
                        step_dn    <= ~cmd_up;
                        adc_reload <= cmd_reload;
                        hold_start <= 1'b1;
                        step_sel   <= cmd_sel;
                        state      <= HOLD;
                    end
                end
                HOLD: begin
                    // Buttons are ignored until the timer expires
                    if (hold_done) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// ==== design/chart_drag.sv ====
`timescale 1ns/1ns

module chart_drag (
    input  logic                         clk,
    input  logic                         rst,
    mouse_if.drag                        mouse,
    output logic [osc_ui_pkg::OFS_W-1:0] x_offset,
    output logic [osc_ui_pkg::OFS_W-1:0] y_offset,
    output logic                         x_neg,
    output logic                         y_neg
);

    logic [osc_ui_pkg::POS_W-1:0] anchor_x;
    logic [osc_ui_pkg::POS_W-1:0] anchor_y;
    logic [osc_ui_pkg::POS_W-1:0] dist_x;
    logic [osc_ui_pkg::POS_W-1:0] dist_y;
    logic                         in_win;
    logic                         ax_ge;
    logic                         ay_ge;

    ////////////////////
    // Window test and distances
    ////////////////////
    assign in_win = (mouse.x >= osc_ui_pkg::DISP_X) &&
                    (mouse.x <= osc_ui_pkg::DISP_X + osc_ui_pkg::DISP_W) &&
                    (mouse.y >= osc_ui_pkg::DISP_Y) &&
                    (mouse.y <= osc_ui_pkg::DISP_Y + osc_ui_pkg::DISP_H);

    assign ax_ge  = anchor_x >= mouse.x;
    assign ay_ge  = anchor_y >= mouse.y;
    assign dist_x = ax_ge ? (anchor_x - mouse.x) : (mouse.x - anchor_x);
    assign dist_y = ay_ge ? (anchor_y - mouse.y) : (mouse.y - anchor_y);

    always_ff @(posedge clk) begin
        if (rst) begin
            anchor_x <= '0;
            anchor_y <= '0;
            x_offset <= '0;
            y_offset <= '0;
            x_neg    <= 1'b0;
            y_neg    <= 1'b0;
        end else if (!in_win) begin
            // Anchor tracks the pointer until it enters the window
            anchor_x <= mouse.x;
            anchor_y <= mouse.y;
        end else if (mouse.left) begin
            x_offset <= dist_x[osc_ui_pkg::OFS_W-1:0];
            y_offset <= dist_y[osc_ui_pkg::OFS_W-1:0];
            x_neg    <= ax_ge;
            y_neg    <= ay_ge;
        end
    end

endmodule

// ==== design/osc_user_interface.sv ====
`timescale 1ns/1ns

module osc_user_interface (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         left_mouse,
    input  logic                         right_mouse,
    input  logic                         middle_mouse,
    input  logic [osc_ui_pkg::POS_W-1:0] xpos,
    input  logic [osc_ui_pkg::POS_W-1:0] ypos,
    output logic [osc_ui_pkg::OFS_W-1:0] x_mouse_pos,
    output logic [osc_ui_pkg::OFS_W-1:0] y_mouse_pos,
    output logic                         minus_x,
    output logic                         minus_y,
    output logic [osc_ui_pkg::OUT_W-1:0] count_adc,
    output logic [osc_ui_pkg::OUT_W-1:0] trigger,
    output logic [osc_ui_pkg::OUT_W-1:0] trig_clk
);

    logic                     step_up;
    logic                     step_dn;
    logic                     adc_reload;
    logic                     hold_start;
    logic                     hold_done;
    logic                     adc_low;
    osc_ui_pkg::setting_sel_t step_sel;
    logic                     adc_hit;
    logic                     level_hit;
    logic                     clk_hit;

    ////////////////////
    // Mouse bundle
    ////////////////////
    mouse_if mouse ();

    assign mouse.left   = left_mouse;
    assign mouse.right  = right_mouse;
    assign mouse.middle = middle_mouse;
    assign mouse.x      = xpos;
    assign mouse.y      = ypos;

    ui_controller ctrl_i (
        .clk        (clk),
        .rst        (rst),
        .mouse      (mouse.ctrl),
        .adc_low    (adc_low),
        .hold_done  (hold_done),
        .step_up    (step_up),
        .step_dn    (step_dn),
        .adc_reload (adc_reload),
        .hold_start (hold_start),
        .step_sel   (step_sel)
    );

    hold_timer hold_i (
        .clk   (clk),
        .rst   (rst),
        .start (hold_start),
        .done  (hold_done)
    );

    ////////////////////
    // Setting counters
    ////////////////////
    // Route strobes to the selected counter
    assign adc_hit   = step_sel == osc_ui_pkg::SEL_ADC;
    assign level_hit = step_sel == osc_ui_pkg::SEL_TRIG_LEVEL;
    assign clk_hit   = step_sel == osc_ui_pkg::SEL_TRIG_CLK;

    setting_counter #(
        .RESET_VALUE (osc_ui_pkg::ADC_RESET_VALUE),
        .HAS_RELOAD  (1'b1)
    ) adc_cnt (
        .clk    (clk),
        .rst    (rst),
        .up     (step_up & adc_hit),
        .dn     (step_dn & adc_hit),
        .reload (adc_reload),
        .value  (count_adc),
        .low    (adc_low)
    );

    setting_counter #(
        .RESET_VALUE ('0),
        .HAS_RELOAD  (1'b0)
    ) trig_level_cnt (
        .clk    (clk),
        .rst    (rst),
        .up     (step_up & level_hit),
        .dn     (step_dn & level_hit),
        .reload (1'b0),
        .value  (trigger),
        .low    ()
    );

    setting_counter #(
        .RESET_VALUE ('0),
        .HAS_RELOAD  (1'b0)
    ) trig_clk_cnt (
        .clk    (clk),
        .rst    (rst),
        .up     (step_up & clk_hit),
        .dn     (step_dn & clk_hit),
        .reload (1'b0),
        .value  (trig_clk),
        .low    ()
    );

    chart_drag drag_i (
        .clk      (clk),
        .rst      (rst),
        .mouse    (mouse.drag),
        .x_offset (x_mouse_pos),
        .y_offset (y_mouse_pos),
        .x_neg    (minus_x),
        .y_neg    (minus_y)
    );

endmodule

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

endmodule

// ==== verif/osc_user_interface_assertions.sv ====
`timescale 1ns/1ns

module osc_user_interface_assertions (
    input logic clk,
    input logic rst,
    input logic step_up,
    input logic step_dn,
    input logic hold_start
);

    int   gap;
    logic strobe;

    assign strobe = step_up | step_dn;

    // Cycles since the last strobe, saturating at the hold length
    always_ff @(posedge clk) begin
        if (rst) begin
            gap <= osc_ui_pkg::HOLD_CYCLES;
        end else if (strobe) begin
            gap <= 0;
        end else if (gap < osc_ui_pkg::HOLD_CYCLES) begin
            gap <= gap + 1;
        end
    end

    no_double_strobe: assert property (@(posedge clk) disable iff (rst)
        !(step_up && step_dn))
        else $error("step_up and step_dn high in the same cycle");

    hold_with_strobe: assert property (@(posedge clk) disable iff (rst)
        hold_start == (step_up ^ step_dn))
        else $error("hold_start does not match exactly one strobe");

    strobe_spacing: assert property (@(posedge clk) disable iff (rst)
        strobe |-> (gap >= osc_ui_pkg::HOLD_CYCLES))
        else $error("strobe fired inside the hold window");

endmodule

bind ui_controller osc_user_interface_assertions ctrl_assert_i (
    .clk        (clk),
    .rst        (rst),
    .step_up    (step_up),
    .step_dn    (step_dn),
    .hold_start (hold_start)
);

// ==== verif/osc_user_interface_tb.sv ====
`timescale 1ns/1ns

module osc_user_interface_tb;

    typedef struct packed {
        int          test_id;
        logic        left;
        logic        right;
        logic        middle;
        logic [11:0] x;
        logic [11:0] y;
        int          cycles;
        logic [11:0] exp_adc;
        logic [11:0] exp_trig;
        logic [11:0] exp_clk;
        logic [10:0] exp_xo;
        logic [10:0] exp_yo;
        logic        exp_xn;
        logic        exp_yn;
    } stim_t;

    logic        clk;
    logic        rst;
    logic        left_mouse;
    logic        right_mouse;
    logic        middle_mouse;
    logic [11:0] xpos;
    logic [11:0] ypos;
    logic [10:0] x_mouse_pos;
    logic [10:0] y_mouse_pos;
    logic        minus_x;
    logic        minus_y;
    logic [11:0] count_adc;
    logic [11:0] trigger;
    logic [11:0] trig_clk;

    stim_t  stim_q[$];
    integer seed;
    int     errors;
    int     checks;
    int     test_errors;
    int     tests_run;
    int     cycle_count;
    int     cycle_limit;

    // Reference model state
    logic [19:0] m_adc;
    logic [19:0] m_lvl;
    logic [19:0] m_clk;
    int          m_busy;
    logic        pend_ok;
    logic        pend_up;
    logic        pend_reload;
    int          pend_sel;
    logic [11:0] m_ax;
    logic [11:0] m_ay;
    logic [10:0] m_xo;
    logic [10:0] m_yo;
    logic        m_xn;
    logic        m_yn;

    tb_clock_gen #(.PERIOD(20)) clk_gen_i (.clk(clk));

    osc_user_interface osc_user_interface_i (
        .clk          (clk),
        .rst          (rst),
        .left_mouse   (left_mouse),
        .right_mouse  (right_mouse),
        .middle_mouse (middle_mouse),
        .xpos         (xpos),
        .ypos         (ypos),
        .x_mouse_pos  (x_mouse_pos),
        .y_mouse_pos  (y_mouse_pos),
        .minus_x      (minus_x),
        .minus_y      (minus_y),
        .count_adc    (count_adc),
        .trigger      (trigger),
        .trig_clk     (trig_clk)
    );

    function automatic int rand_range(input int lo, input int hi);
        rand_range = lo + ({$random(seed)} % (hi - lo + 1));
    endfunction

    function automatic string test_name(input int id);
        case (id)
            0: test_name = "reset values";
            1: test_name = "adc up at x=700";
            2: test_name = "trigger level up at x=300";
            3: test_name = "trigger clock down at x=50";
            4: test_name = "press held for three holds";
            5: test_name = "chart drag";
            6: test_name = "presses outside all regions";
            default: test_name = "adc underflow reload";
        endcase
    endfunction

    task automatic add_entry(input int id, input logic l, input logic r, input logic m,
                             input int x, input int y, input int cycles);
        stim_t e;
        e = '0;
        e.test_id = id;
        e.left    = l;
        e.right   = r;
        e.middle  = m;
        e.x       = x;
        e.y       = y;
        e.cycles  = cycles;
        stim_q.push_back(e);
    endtask

    task automatic build_table();
        int k;
        int ay;
        add_entry(0, 0, 0, 0, 0, 0, 4);
        // Short presses, each followed by a release longer than the hold
        for (k = 0; k < 32; k++) begin
            add_entry(1, 0, 1, 1, 700, 20, 10);
            add_entry(1, 0, 0, 0, 700, 20, 1000);
        end
        for (k = 0; k < 32; k++) begin
            add_entry(2, 0, 1, 1, 300, 20, 10);
            add_entry(2, 0, 0, 0, 300, 20, 1000);
        end
        for (k = 0; k < 32; k++) begin
            add_entry(3, 1, 0, 0, 50, 20, 10);
            add_entry(3, 0, 0, 0, 50, 20, 1000);
        end
        // Level accumulator down to 29 so only the third held step moves the output
        for (k = 0; k < 3; k++) begin
            add_entry(4, 1, 0, 1, 300, 20, 10);
            add_entry(4, 0, 0, 0, 300, 20, 1000);
        end
        add_entry(4, 0, 1, 1, 300, 20, 3 * osc_ui_pkg::HOLD_CYCLES);
        add_entry(4, 0, 0, 0, 300, 20, 1010);
        // One step back down tells three held steps from four
        add_entry(4, 1, 0, 1, 300, 20, 10);
        add_entry(4, 0, 0, 0, 300, 20, 1000);
        // Anchor left of the window, then drag above and below it and release
        ay = rand_range(150, 450);
        add_entry(5, 0, 0, 0, rand_range(120, 199), ay, 3);
        add_entry(5, 1, 0, 0, rand_range(200, 800), rand_range(100, ay), 3);
        add_entry(5, 1, 0, 0, rand_range(200, 800), rand_range(ay + 1, 500), 3);
        add_entry(5, 0, 0, 0, rand_range(200, 800), rand_range(100, 500), 3);
        // Anchor right of the window, then drag back inside
        add_entry(5, 0, 0, 0, rand_range(801, 900), rand_range(100, 500), 3);
        add_entry(5, 1, 0, 0, rand_range(200, 800), rand_range(100, 500), 3);
        add_entry(6, 1, 1, 1, rand_range(1001, 4095), 20, 20);
        add_entry(6, 0, 1, 1, 100, 20, 20);
        add_entry(6, 0, 1, 1, 500, 20, 20);
        add_entry(6, 1, 0, 1, 1000, 600, 20);
        add_entry(6, 0, 0, 0, 1000, 600, 10);
        // 988 held steps take the ADC from 992 down to 4
        add_entry(7, 1, 0, 1, 700, 20, 987 * (osc_ui_pkg::HOLD_CYCLES + 2) + 10);
        add_entry(7, 0, 0, 0, 700, 20, 2020);
    endtask

    // One rising edge of the reference model
    task automatic model_edge(input stim_t e);
        logic        cmd_ok;
        logic        cmd_up;
        logic        cmd_reload;
        int          cmd_sel;
        logic        side;
        logic        in_win;
        logic [11:0] dx;
        logic [11:0] dy;
        cmd_ok     = 1'b0;
        cmd_up     = e.right;
        cmd_reload = 1'b0;
        cmd_sel    = 0;
        side       = e.left | e.right;
        if (m_busy > 0) begin
            m_busy = m_busy - 1;
        end else begin
            if (m_adc < osc_ui_pkg::ADC_MIN) begin
                cmd_ok     = 1'b1;
                cmd_up     = 1'b1;
                cmd_reload = 1'b1;
            end else if (e.middle && side && e.x > 500 && e.x < 1000) begin
                cmd_ok = 1'b1;
            end else if (e.middle && side && e.x > 100 && e.x < 500) begin
                cmd_ok  = 1'b1;
                cmd_sel = 1;
            end else if (side && e.x < 100) begin
                cmd_ok  = 1'b1;
                cmd_sel = 2;
            end
            if (cmd_ok) begin
                m_busy = osc_ui_pkg::HOLD_CYCLES + 1;
            end
        end
        // Counters see the strobe registered on the previous edge
        if (pend_ok) begin
            case (pend_sel)
                0: m_adc = pend_reload ? 20'd100 : (pend_up ? m_adc + 1 : m_adc - 1);
                1: m_lvl = pend_up ? m_lvl + 1 : m_lvl - 1;
                default: m_clk = pend_up ? m_clk + 1 : m_clk - 1;
            endcase
        end
        pend_ok     = cmd_ok;
        pend_up     = cmd_up;
        pend_reload = cmd_reload;
        pend_sel    = cmd_sel;
        in_win = e.x >= 200 && e.x <= 800 && e.y >= 100 && e.y <= 500;
        if (!in_win) begin
            m_ax = e.x;
            m_ay = e.y;
        end else if (e.left) begin
            dx   = (m_ax >= e.x) ? m_ax - e.x : e.x - m_ax;
            dy   = (m_ay >= e.y) ? m_ay - e.y : e.y - m_ay;
            m_xo = dx[10:0];
            m_yo = dy[10:0];
            m_xn = m_ax >= e.x;
            m_yn = m_ay >= e.y;
        end
    endtask

    task automatic fill_expected();
        stim_t e;
        int    total;
        total = 0;
        m_adc = 20'd960;
        m_lvl = '0;
        m_clk = '0;
        m_busy = 0;
        pend_ok = 1'b0;
        pend_up = 1'b0;
        pend_reload = 1'b0;
        pend_sel = 0;
        m_ax = '0;
        m_ay = '0;
        m_xo = '0;
        m_yo = '0;
        m_xn = 1'b0;
        m_yn = 1'b0;
        foreach (stim_q[i]) begin
            e = stim_q[i];
            repeat (e.cycles) model_edge(e);
            e.exp_adc  = m_adc[15:4];
            e.exp_trig = m_lvl[15:4];
            e.exp_clk  = m_clk[15:4];
            e.exp_xo   = m_xo;
            e.exp_yo   = m_yo;
            e.exp_xn   = m_xn;
            e.exp_yn   = m_yn;
            stim_q[i]  = e;
            total      = total + e.cycles;
        end
        cycle_limit = (total + 16) * 11 / 10;
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        checks = checks + 1;
        if (got !== expected) begin
            errors      = errors + 1;
            test_errors = test_errors + 1;
            $display("MISMATCH at %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
        end
    endtask

    task automatic run_table();
        stim_t e;
        foreach (stim_q[i]) begin
            e            = stim_q[i];
            left_mouse   = e.left;
            right_mouse  = e.right;
            middle_mouse = e.middle;
            xpos         = e.x;
            ypos         = e.y;
            repeat (e.cycles) @(posedge clk);
            @(negedge clk);
            check_value($sformatf("entry %0d count_adc", i), count_adc, e.exp_adc);
            check_value($sformatf("entry %0d trigger", i), trigger, e.exp_trig);
            check_value($sformatf("entry %0d trig_clk", i), trig_clk, e.exp_clk);
            check_value($sformatf("entry %0d x_mouse_pos", i), x_mouse_pos, e.exp_xo);
            check_value($sformatf("entry %0d y_mouse_pos", i), y_mouse_pos, e.exp_yo);
            check_value($sformatf("entry %0d minus_x", i), minus_x, e.exp_xn);
            check_value($sformatf("entry %0d minus_y", i), minus_y, e.exp_yn);
            if (i == stim_q.size() - 1 || stim_q[i + 1].test_id != e.test_id) begin
                $display("Test %0d (%s): %s", e.test_id, test_name(e.test_id),
                         (test_errors == 0) ? "pass" : "FAIL");
                tests_run   = tests_run + 1;
                test_errors = 0;
            end
        end
    endtask

    ////////////////////
    // Timeout
    ////////////////////
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("Timeout: run did not finish within %0d clock cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        rst          = 1'b1;
        left_mouse   = 1'b0;
        right_mouse  = 1'b0;
        middle_mouse = 1'b0;
        xpos         = '0;
        ypos         = '0;
        seed         = 55499;
        errors       = 0;
        checks       = 0;
        test_errors  = 0;
        tests_run    = 0;
        cycle_count  = 0;
        cycle_limit  = 0;
        build_table();
        fill_expected();
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        run_table();
        $display("Tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== osc_user_interface.f ====
design/osc_ui_pkg.sv
design/mouse_if.sv
design/hold_timer.sv
design/setting_counter.sv
design/ui_controller.sv
design/chart_drag.sv
design/osc_user_interface.sv
verif/tb_clock_gen.sv
verif/osc_user_interface_assertions.sv
verif/osc_user_interface_tb.sv

// ==== Bender.yml ====
package:
  name: osc_user_interface

sources:
  # Design, package first
  - files:
      - design/osc_ui_pkg.sv
      - design/mouse_if.sv
      - design/hold_timer.sv
      - design/setting_counter.sv
      - design/ui_controller.sv
      - design/chart_drag.sv
      - design/osc_user_interface.sv

  # Verification
  - target: simulation
    files:
      - verif/tb_clock_gen.sv
      - verif/osc_user_interface_assertions.sv
      - verif/osc_user_interface_tb.sv
